//--- oledCtrl.f
hw/oledLinkPkg.sv
hw/oledCmdPkg.sv
hw/oledByteIf.sv
hw/oledByteQueue.sv
hw/oledInitSeq.sv
hw/oledSpiTx.sv
hw/oledCtrl.sv
bench/oledPanelModel.sv
bench/oledCtrlTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the oledCtrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module oledCtrlTb \
    -f oledCtrl.f \
    -o oledCtrlSim

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/oledCtrlSim

//--- bench/oledCtrlTb.sv
`timescale 1ns/1ps

module oledCtrlTb import oledLinkPkg::*, oledCmdPkg::*; ();

    localparam int TABLE_LEN      = 16;
    localparam int BURST_LEN      = 40;
    localparam int BYTE_CYCLES    = 25;     // Bound per byte on the pins
    localparam int CREDIT_TIMEOUT = 100;

    // Host stimulus {isData, value}
    // Column and page window, a small glyph, display on again
    localparam logic [8:0] stimTable [TABLE_LEN] = '{
        9'h021, 9'h000, 9'h07F, 9'h022,
        9'h000, 9'h007, 9'h1FF, 9'h181,
        9'h181, 9'h1FF, 9'h100, 9'h13C,
        9'h142, 9'h142, 9'h13C, 9'h0AF
    };

    logic       clk;
    logic       rst_n;
    logic       hostValid;
    logic       hostIsData;
    logic [7:0] hostByte;
    logic       hostCredit;
    logic       csN;
    logic       sclk;
    logic       sdin;
    logic       dc;
    logic       initDone;

    int         credits;            // Host credit counter
    int         pushed;
    int         creditPulses;
    int         checkedCnt;         // Panel bytes already compared
    logic       initSeen;
    logic [8:0] expQ [$];           // Expected pin traffic with the init table first

    oledCtrl #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .SCLK_HALF  (SCLK_HALF)
    ) UUT (.*);

    oledPanelModel panel (.*);

    always #50 clk = ~clk;          // 100 ns period

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic flagMismatch(input string name, input int expected, input int actual);
        stopRun($sformatf("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        xorshift = x ^ (x << 5);
    endfunction

    // Advance to the falling edge where inputs change and outputs are sampled
    task automatic stepCycle();
        @(negedge clk);
        if (hostCredit) begin
            credits++;
            creditPulses++;
        end
        assert (creditPulses <= pushed)
            else flagMismatch("credit return", pushed, creditPulses);
        assert (!(csN && sclk)) else flagMismatch("idle sclk", 0, 1);   // Idle bus
        if (initSeen) begin
            assert (initDone) else flagMismatch("initDone held", 1, 0);
        end else if (initDone) begin
            initSeen = 1'b1;
            // Only the table may reach the pins before initDone
            assert (panel.rxQ.size() == INIT_LEN)
                else flagMismatch("bytes before initDone", INIT_LEN, panel.rxQ.size());
        end
    endtask

    task automatic pushByte(input logic [8:0] entry);
        int waited;
        waited = 0;
        while (credits == 0) begin          // Held off without credits
            hostValid = 1'b0;
            stepCycle();
            waited++;
            if (waited > CREDIT_TIMEOUT) begin
                stopRun("Timeout, the queue returned no host credit");
            end
        end
        hostValid  = 1'b1;
        hostIsData = entry[8];
        hostByte   = entry[7:0];
        credits--;
        pushed++;
        expQ.push_back(entry);
        stepCycle();
        hostValid = 1'b0;                   // Next push may raise it again at once
    endtask

    task automatic waitCaptured(input int count);
        int waited;
        int limit;
        waited = 0;
        limit  = (count - panel.rxQ.size()) * BYTE_CYCLES + 20;
        while (panel.rxQ.size() < count) begin
            stepCycle();
            waited++;
            if (waited > limit) begin
                stopRun($sformatf("Timeout, only %0d of %0d bytes reached the panel",
                                  panel.rxQ.size(), count));
            end
        end
    endtask

    task automatic compareCaptured(input string name, input int upto);
        for (int i = checkedCnt; i < upto; i++) begin
            assert (panel.rxQ[i] === expQ[i])
                else flagMismatch($sformatf("%s %0d", name, i),
                                  int'(expQ[i]), int'(panel.rxQ[i]));
        end
        checkedCnt = upto;
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          waited;
        int          gap;
        logic [31:0] rngState;
        clk          = 1'b0;
        rst_n        = 1'b0;
        hostValid    = 1'b0;
        hostIsData   = 1'b0;
        hostByte     = 8'h00;
        credits      = QUEUE_DEPTH;         // Host owns the whole queue
        pushed       = 0;
        creditPulses = 0;
        checkedCnt   = 0;
        initSeen     = 1'b0;
        for (int i = 0; i < INIT_LEN; i++) begin
            expQ.push_back({1'b0, initSeqRom[i]});  // Commands only
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (csN === 1'b1) else flagMismatch("reset csN", 1, int'(csN));
        assert (sclk === 1'b0) else flagMismatch("reset sclk", 0, int'(sclk));
        assert (sdin === 1'b0) else flagMismatch("reset sdin", 0, int'(sdin));
        assert (dc === 1'b0) else flagMismatch("reset dc", 0, int'(dc));
        assert (initDone === 1'b0) else flagMismatch("reset initDone", 0, int'(initDone));
        assert (hostCredit === 1'b0) else flagMismatch("reset hostCredit", 0, int'(hostCredit));

        // Fill the queue back to back while the table still plays
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            assert (credits == QUEUE_DEPTH - i)
                else flagMismatch("early credits", QUEUE_DEPTH - i, credits);
            pushByte(stimTable[i]);
        end

        waitCaptured(INIT_LEN);
        waited = 0;
        while (!initDone) begin             // One cycle after the last done
            stepCycle();
            waited++;
            if (waited > 4) begin
                stopRun("Timeout, initDone did not rise after the twelfth init byte");
            end
        end
        compareCaptured("init byte", INIT_LEN);

        for (int i = QUEUE_DEPTH; i < TABLE_LEN; i++) begin
            pushByte(stimTable[i]);
        end
        waitCaptured(expQ.size());
        compareCaptured("table byte", expQ.size());

        // Random burst with gaps of 0 to 7 idle cycles
        rngState = 32'h868a_6282;
        for (int i = 0; i < BURST_LEN; i++) begin
            rngState = xorshift(rngState);
            gap      = int'(rngState[11:9]);
            repeat (gap) stepCycle();
            pushByte(rngState[8:0]);
        end
        waitCaptured(expQ.size());
        compareCaptured("burst byte", expQ.size());

        repeat (4) stepCycle();
        assert (panel.rxQ.size() == expQ.size())
            else flagMismatch("captured count", expQ.size(), panel.rxQ.size());
        assert (creditPulses == pushed) else flagMismatch("credit pulses", pushed, creditPulses);
        assert (panel.frameErrors == 0)
            else flagMismatch("panel frame errors", 0, panel.frameErrors);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- bench/oledPanelModel.sv
`timescale 1ns/1ps

// Panel side of the SPI link, collects one {dc, byte} per csN frame
module oledPanelModel (
    input logic csN,
    input logic sclk,
    input logic sdin,
    input logic dc
);

    logic [8:0] rxQ [$];            // Completed frames in arrival order
    logic [7:0] shiftIn;
    logic       dcFirst;            // dc seen at the first bit
    int         bitCnt = 0;
    int         frameErrors = 0;    // Wrong bit count or dc moving mid byte

    // csN rise closes a frame, sclk rise while selected takes a bit
    always @(posedge sclk or posedge csN) begin
        if (csN) begin
            if (bitCnt != 0) begin
                if (bitCnt != 8) begin
                    frameErrors++;
                end
                rxQ.push_back({dcFirst, shiftIn});
            end
            bitCnt = 0;             // Reset edge lands here with nothing framed
        end else begin
            if (bitCnt == 0) begin
                dcFirst = dc;
            end else if (dc != dcFirst) begin
                frameErrors++;
            end
            shiftIn = {shiftIn[6:0], sdin};     // MSB first
            bitCnt++;
        end
    end

endmodule

//--- hw/oledCtrl.sv
`timescale 1ns/1ps

module oledCtrl #(
    parameter int QUEUE_DEPTH = oledLinkPkg::QUEUE_DEPTH,  // Host credits after reset
    parameter int SCLK_HALF   = oledLinkPkg::SCLK_HALF     // clk cycles per sclk half
) (
    input  logic       clk,
    input  logic       rst_n,
    // Host side, credit flow control
    input  logic       hostValid,
    input  logic       hostIsData,
    input  logic [7:0] hostByte,
    output logic       hostCredit,
    // Panel SPI pins
    output logic       csN,
    output logic       sclk,
    output logic       sdin,
    output logic       dc,
    output logic       initDone
);

    ////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////

    oledByteIf queueToSeq (.clk(clk));
    oledByteIf seqToTx    (.clk(clk));

    // Host bytes wait here
    oledByteQueue #(
        .DEPTH(QUEUE_DEPTH)
    ) uQueue (
        .clk        (clk),
        .rst_n      (rst_n),
        .hostValid  (hostValid),
        .hostIsData (hostIsData),
        .hostByte   (hostByte),
        .hostCredit (hostCredit),
        .out        (queueToSeq.sender)
    );

    // Power-up table first, then pass-through
    oledInitSeq uSeq (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (queueToSeq.receiver),
        .out      (seqToTx.sender),
        .initDone (initDone)
    );

    oledSpiTx #(
        .HALF_CYCLES(SCLK_HALF)
    ) uTx (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (seqToTx.receiver),
        .csN   (csN),
        .sclk  (sclk),
        .sdin  (sdin),
        .dc    (dc)
    );

endmodule

//--- hw/oledSpiTx.sv
`timescale 1ns/1ps

module oledSpiTx import oledLinkPkg::*; #(
    parameter int HALF_CYCLES = SCLK_HALF   // clk cycles per sclk half
) (
    input  logic        clk,
    input  logic        rst_n,
    oledByteIf.receiver in,
    output logic        csN,    // Chip select, low for the whole byte
    output logic        sclk,   // Panel samples on rising edge
    output logic        sdin,   // Serial data, MSB first
    output logic        dc      // Held from accept to next accept
);

    localparam int DIV_W = $clog2(HALF_CYCLES + 1);

    // Step 1 is setup, even steps 2..16 sclk low, odd steps 3..17 sclk high
    localparam logic [4:0] STEP_IDLE  = 5'd0;
    localparam logic [4:0] STEP_SETUP = 5'd1;
    localparam logic [4:0] STEP_LAST  = 5'd17;

    logic [4:0]       step;
    logic [DIV_W-1:0] divCnt;       // Half period divider
    logic [7:0]       shiftReg;
    logic             dcHeld;
    logic             done;         // One-cycle end of byte
    logic             busy;
    logic             halfEnd;
    logic             highPhase;
    logic             accept;
    logic             shiftBit;     // Next bit onto sdin

    assign busy      = (step != STEP_IDLE);
    assign accept    = !busy && in.valid;
    assign halfEnd   = (divCnt == DIV_W'(HALF_CYCLES - 1));
    assign highPhase = step[0] && (step > STEP_SETUP);
    assign shiftBit  = (step == STEP_SETUP)
                     || (highPhase && halfEnd && (step != STEP_LAST));

    assign dc        = dcHeld;
    assign in.credit = done;        // Slot free again with done

    ////////////////////////////////////////////////////////////
    // Step sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step   <= STEP_IDLE;
            divCnt <= '0;
            csN    <= 1'b1;
            sclk   <= 1'b0;
            sdin   <= 1'b0;
            dcHeld <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (step)
                STEP_IDLE: begin
                    if (accept) begin
                        dcHeld <= in.item.isData;
                        csN    <= 1'b0;         // Select panel next cycle
                        step   <= STEP_SETUP;
                    end
                end
                STEP_SETUP: begin
                    divCnt <= '0;
                    step   <= step + 1'b1;      // First low half with MSB
                end
                default: begin
                    if (!halfEnd) begin
                        divCnt <= divCnt + 1'b1;
                    end else begin
                        divCnt <= '0;
                        if (!highPhase) begin
                            sclk <= 1'b1;       // Rising edge latches bit
                            step <= step + 1'b1;
                        end else if (step == STEP_LAST) begin
                            csN  <= 1'b1;       // Deselect, byte complete
                            sclk <= 1'b0;
                            done <= 1'b1;
                            step <= STEP_IDLE;
                        end else begin
                            sclk <= 1'b0;
                            step <= step + 1'b1;
                        end
                    end
                end
            endcase

            if (shiftBit) begin
                sdin <= shiftReg[7];
            end
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg <= in.item.value;
        end else if (shiftBit) begin
            shiftReg <= {shiftReg[6:0], 1'b0};
        end
    end

    // Sender held one credit, so a second item mid-byte breaks the link
    assert property (@(posedge in.clk) disable iff (!rst_n)
        busy |-> !in.valid)
        else $error("oledSpiTx: item arrived while a byte is in progress");

endmodule

//--- hw/oledInitSeq.sv
`timescale 1ns/1ps

module oledInitSeq import oledLinkPkg::*, oledCmdPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    oledByteIf.receiver in,
    oledByteIf.sender   out,
    output logic        initDone
);

    localparam int IDX_W = $clog2(INIT_LEN + 1);

    logic [IDX_W-1:0] tableIdx;     // Next table entry to issue
    logic [IDX_W-1:0] romIdx;
    logic             txCredit;     // Transmitter slot free
    logic             passThru;     // Phase flag, high after init
    logic             tableLeft;
    logic             allIssued;
    oledByte_t        tableItem;

    assign tableLeft = (tableIdx < IDX_W'(INIT_LEN));
    assign allIssued = !tableLeft;
    assign romIdx    = tableLeft ? tableIdx : '0;   // Keep ROM index in range
    assign tableItem = '{isData: DC_CMD, value: initSeqRom[romIdx]};

    ////////////////////////////////////////////////////////////
    // Link muxing
    ////////////////////////////////////////////////////////////

    // Table bytes first, then queue items straight through
    assign out.valid = passThru ? in.valid : (tableLeft && txCredit);
    assign out.item  = passThru ? in.item  : tableItem;

    // No credits to the queue while the table plays.
    // Done pulse of the last table byte hands the slot over,
    // after that every credit is forwarded
    assign in.credit = out.credit && allIssued;

    assign initDone = passThru;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tableIdx <= '0;
            txCredit <= 1'(TX_SLOTS);
            passThru <= 1'b0;
        end else begin
            if (!passThru && out.valid) begin
                tableIdx <= tableIdx + 1'b1;
            end
            if (allIssued && out.credit) begin
                passThru <= 1'b1;       // Sticky until reset
            end

            // Track the slot in both phases
            case ({out.valid, out.credit})
                2'b10:   txCredit <= 1'b0;
                2'b01:   txCredit <= 1'b1;
                default: txCredit <= txCredit;
            endcase
        end
    end

    // Covers the queue as well once items pass through
    assert property (@(posedge out.clk) disable iff (!rst_n)
        out.valid |-> txCredit)
        else $error("oledInitSeq: byte sent to transmitter without credit");

    // Queue gets no slot until the table is done
    assert property (@(posedge in.clk) disable iff (!rst_n)
        !passThru |-> !in.valid)
        else $error("oledInitSeq: queue item offered during init");

endmodule

//--- hw/oledByteQueue.sv
`timescale 1ns/1ps

module oledByteQueue import oledLinkPkg::*; #(
    parameter int DEPTH = QUEUE_DEPTH
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hostValid,
    input  logic       hostIsData,
    input  logic [7:0] hostByte,
    output logic       hostCredit,
    oledByteIf.sender  out
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    oledByte_t        mem [DEPTH];     // Entry storage
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] fill;            // Entries held
    logic [CREDIT_W-1:0] txCredits;    // Downstream slots granted to us
    logic             pop;
    oledByte_t        hostItem;

    // Wrap at DEPTH, so non power of two depths work too
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        nextPtr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign hostItem = '{isData: hostIsData, value: hostByte};

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    // Head entry goes out as soon as a downstream slot is granted
    assign pop       = (fill != '0) && (txCredits != '0);
    assign out.valid = pop;
    assign out.item  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (hostValid) begin
            mem[wrPtr] <= hostItem;     // Visible to reader next cycle
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            fill       <= '0;
            txCredits  <= '0;           // Sequencer owns the slot during init
            hostCredit <= 1'b0;
        end else begin
            if (hostValid) wrPtr <= nextPtr(wrPtr);
            if (pop)       rdPtr <= nextPtr(rdPtr);

            case ({hostValid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;  // Idle or push and pop together
            endcase

            case ({out.credit, pop})
                2'b10:   txCredits <= txCredits + 1'b1;
                2'b01:   txCredits <= txCredits - 1'b1;
                default: txCredits <= txCredits;
            endcase

            hostCredit <= pop;          // Freed entry back to host
        end
    end

    // Host pushing into a full queue has spent credits it never had
    assert property (@(posedge clk) disable iff (!rst_n)
        hostValid |-> (fill != CNT_W'(DEPTH)))
        else $error("oledByteQueue: push into full queue, host credit overrun");

endmodule

//--- hw/oledByteIf.sv
`timescale 1ns/1ps

// Credit-based byte link
// Sender may raise valid only with a nonzero credit count,
// each valid cycle spends one credit, each credit pulse returns one
interface oledByteIf import oledLinkPkg::*; (
    input logic clk
);

    logic      valid;   // Item offered this cycle
    oledByte_t item;    // Tagged byte
    logic      credit;  // One-cycle pulse, one slot freed at receiver

    modport sender (
        input  clk,
        output valid,
        output item,
        input  credit
    );

    modport receiver (
        input  clk,
        input  valid,
        input  item,
        output credit
    );

endinterface

//--- hw/oledCmdPkg.sv
package oledCmdPkg;

    ////////////////////////////////////////////////////////////
    // SSD1306 command opcodes
    ////////////////////////////////////////////////////////////

    // Fundamental
    localparam logic [7:0] CMD_DISPLAY_OFF  = 8'hAE;   // Sleep mode
    localparam logic [7:0] CMD_DISPLAY_ON   = 8'hAF;
    localparam logic [7:0] CMD_SET_CONTRAST = 8'h81;
    localparam logic [7:0] CMD_RESUME_RAM   = 8'hA4;   // Follow RAM contents

    // Timing and driving
    localparam logic [7:0] CMD_SET_CLK_DIV  = 8'hD5;
    localparam logic [7:0] CMD_SET_MUX      = 8'hA8;   // Multiplex ratio
    localparam logic [7:0] CMD_SET_OFFSET   = 8'hD3;
    localparam logic [7:0] CMD_CHARGE_PUMP  = 8'h8D;   // Internal DC-DC

    // Addressing and layout
    localparam logic [7:0] CMD_START_LINE   = 8'h40;   // Line 0
    localparam logic [7:0] CMD_MEM_MODE     = 8'h20;
    localparam logic [7:0] CMD_SEG_REMAP    = 8'hA1;   // Column 127 at SEG0
    localparam logic [7:0] CMD_COM_SCAN_DEC = 8'hC8;   // Scan COM[N-1] to COM0

    ////////////////////////////////////////////////////////////
    // Power-up sequence
    ////////////////////////////////////////////////////////////

    localparam int INIT_LEN = 12;

    // Played in order after reset, every entry a command
    localparam logic [7:0] initSeqRom [0:INIT_LEN-1] = '{
        CMD_DISPLAY_OFF,
        CMD_SET_CLK_DIV,
        CMD_SET_MUX,
        CMD_SET_OFFSET,
        CMD_START_LINE,
        CMD_CHARGE_PUMP,
        CMD_MEM_MODE,
        CMD_SEG_REMAP,
        CMD_COM_SCAN_DEC,
        CMD_SET_CONTRAST,
        CMD_RESUME_RAM,
        CMD_DISPLAY_ON      // Panel lights up last
    };

endpackage

//--- hw/oledLinkPkg.sv
package oledLinkPkg;

    ////////////////////////////////////////////////////////////
    // Link sizing
    ////////////////////////////////////////////////////////////

    // Host queue entries, also the host's credits after reset
    localparam int QUEUE_DEPTH = 8;

    // clk cycles per sclk half period
    localparam int SCLK_HALF = 1;

    localparam int TX_SLOTS = 1;    // Transmitter holds one byte at a time
    localparam int CREDIT_W = 2;    // Width of a sender's credit counter

    ////////////////////////////////////////////////////////////
    // Link item
    ////////////////////////////////////////////////////////////

    // Level on the D/C pin
    // High means display data, low means command register
    localparam logic DC_CMD  = 1'b0;
    localparam logic DC_DATA = 1'b1;

    // One tagged byte, 9 bits wide
    typedef struct packed {
        logic       isData;     // 1 data, 0 command
        logic [7:0] value;      // Shifted out MSB first
    } oledByte_t;

endpackage
